/* bench_stats.sv */
// byte totals wrap at 64 bits after the NITERATIONS scaling, latency counts clock cycles only
`timescale 1ns/1ps
`include "dma_bench_macros.svh"

module bench_stats (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   req_start,
	input  logic                   req_is_read,
	input  logic                   rq_fire,
	input  logic                   rc_fire,
	input  logic                   run_active,
	input  logic                   run_start,
	input  logic                   run_done,
	input  logic                   original_update_latency,
	input  dma_bench_pkg::word64_t original_time_at_req,
	input  dma_bench_pkg::word64_t original_time_at_comp,
	input  dma_bench_pkg::word64_t original_bytes_at_req,
	input  dma_bench_pkg::word64_t original_bytes_at_comp,
	output logic                   faked_update_latency,
	output dma_bench_pkg::word64_t faked_current_latency,
	output dma_bench_pkg::word64_t faked_time_at_req,
	output dma_bench_pkg::word64_t faked_time_at_comp,
	output dma_bench_pkg::word64_t faked_bytes_at_req,
	output dma_bench_pkg::word64_t faked_bytes_at_comp
);
	import dma_bench_pkg::*;

	localparam word64_t SCALE = word64_t'(`NITERATIONS);  // replay factor for byte totals

	word64_t lat_cnt_r;      // cycles since first request of the run
	logic    counting_r;     // counter running
	word64_t lat_snap_r;     // latency seen by software
	logic    snap_event;     // beat that closes a latency sample
	word64_t time_req_r;     // accumulated request time
	word64_t time_comp_r;    // accumulated completion time
	word64_t time_req_base;  // accumulator start value
	word64_t time_comp_base;
	word64_t bytes_req_r;    // scaled request bytes
	word64_t bytes_comp_r;   // scaled completion bytes
	logic    update_r;       // run end pulse to software

	// latency counter, armed by the first header of a run
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			lat_cnt_r  <= '0;
			counting_r <= 1'b0;
		end else if (!run_active) begin
			lat_cnt_r  <= '0;  // idle clears
			counting_r <= 1'b0;
		end else if (counting_r || req_start) begin
			lat_cnt_r  <= lat_cnt_r + word64_t'(1);
			counting_r <= 1'b1;
		end
	end

	// reads close on completions, writes on request beats
	assign snap_event = req_is_read ? rc_fire : rq_fire;

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			lat_snap_r <= '0;
		end else if (snap_event) begin
			lat_snap_r <= lat_cnt_r + word64_t'(1);  // count includes this beat
		end
	end

	// time totals restart with each run
	assign time_req_base  = run_start ? word64_t'(0) : time_req_r;
	assign time_comp_base = run_start ? word64_t'(0) : time_comp_r;

	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			time_req_r  <= '0;
			time_comp_r <= '0;
		end else if (original_update_latency) begin
			time_req_r  <= time_req_base + original_time_at_req;
			time_comp_r <= time_comp_base + original_time_at_comp;
		end else if (run_start) begin
			time_req_r  <= '0;
			time_comp_r <= '0;
		end
	end

	// per transfer bytes scaled to the whole run
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			bytes_req_r  <= '0;
			bytes_comp_r <= '0;
		end else if (original_update_latency) begin
			bytes_req_r  <= original_bytes_at_req * SCALE;
			bytes_comp_r <= original_bytes_at_comp * SCALE;
		end
	end

	// one update per run
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			update_r <= 1'b0;
		end else begin
			update_r <= run_done;
		end
	end

	assign faked_update_latency  = update_r;
	assign faked_current_latency = lat_snap_r;
	assign faked_time_at_req     = time_req_r;
	assign faked_time_at_comp    = time_comp_r;
	assign faked_bytes_at_req    = bytes_req_r;
	assign faked_bytes_at_comp   = bytes_comp_r;

endmodule

/* descriptor_replay.sv */
// replays one descriptor NITERATIONS times, mode 2 leaves the caller to keep the address range writable
`timescale 1ns/1ps
`include "dma_bench_macros.svh"

module descriptor_replay #(
	parameter int REPLAY_MODE = `REPLAY_MODE  // 1 same address, 2 successive addresses
) (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      original_engine_valid,
	input  dma_bench_pkg::word64_t    original_size,
	input  dma_bench_pkg::word64_t    original_addr,
	input  dma_bench_pkg::ctrl_byte_t original_control_byte,
	output logic                      faked_engine_valid,
	output dma_bench_pkg::word64_t    faked_size,
	output dma_bench_pkg::word64_t    faked_addr,
	output dma_bench_pkg::ctrl_byte_t faked_control_byte,
	output logic                      run_active,
	output logic                      run_start,
	output logic                      run_done
);
	import dma_bench_pkg::*;

	localparam iter_t      LAST_ITER  = iter_t'(`NITERATIONS);   // final replay index
	localparam logic [7:0] DRAIN_LOAD = 8'(`DRAIN_CYCLES);       // drain counter start

	replay_state_t state_r;        // replay fsm
	iter_t         iter_r;         // current iteration, 1 based
	word64_t       addr_r;         // address shown to the engine
	word64_t       size_r;         // size shown to the engine
	logic          engine_valid_r; // faked descriptor valid
	logic [7:0]    drain_cnt_r;    // remaining drain cycles
	logic          done_r;         // first idle cycle after drain
	logic          eop;            // end of operation from the engine
	logic          last_iter;      // on the final transfer

	assign eop       = original_control_byte[`CTRL_EOP_BIT];
	assign last_iter = (iter_r == LAST_ITER);

	// state, iteration and drain control
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			state_r        <= ST_IDLE;
			iter_r         <= iter_t'(1);
			engine_valid_r <= 1'b0;
			drain_cnt_r    <= 8'd0;
			done_r         <= 1'b0;
		end else begin
			done_r <= 1'b0;  // single cycle pulse
			case (state_r)
				ST_IDLE: begin
					iter_r         <= iter_t'(1);
					engine_valid_r <= 1'b0;
					if (original_engine_valid) begin
						state_r        <= ST_BUSY;
						engine_valid_r <= 1'b1;  // start replay
					end
				end
				ST_BUSY: begin
					if (eop) begin
						iter_r <= iter_r + iter_t'(1);
						if (last_iter) begin
							state_r        <= ST_DRAIN;
							engine_valid_r <= 1'b0;  // hide engine until next descriptor
							drain_cnt_r    <= DRAIN_LOAD;
						end
					end
				end
				ST_DRAIN: begin
					drain_cnt_r <= drain_cnt_r - 8'd1;
					if (drain_cnt_r == 8'd0) begin
						state_r <= ST_IDLE;
						done_r  <= 1'b1;  // seen in the first idle cycle
					end
				end
				default: begin
					state_r        <= ST_IDLE;
					engine_valid_r <= 1'b0;
				end
			endcase
		end
	end

	// descriptor payload, follows the inputs in idle and steps on each eop
	always_ff @(posedge CLK) begin
		if (state_r == ST_IDLE) begin
			size_r <= original_size;
			addr_r <= original_addr;
		end else if ((state_r == ST_BUSY) && eop) begin
			size_r <= original_size;
			if (REPLAY_MODE == 2) begin
				addr_r <= addr_r + size_r;  // next slot in memory
			end else begin
				addr_r <= original_addr;    // same slot again
			end
		end
	end

	// software sees only the final end of operation
	always_comb begin
		faked_control_byte = '0;
		faked_control_byte[`CTRL_EOP_BIT] = eop && last_iter && (state_r == ST_BUSY);
	end

	assign faked_engine_valid = engine_valid_r;
	assign faked_size         = size_r;
	assign faked_addr         = addr_r;

	// run markers for the statistics block
	assign run_active = (state_r != ST_IDLE);
	assign run_start  = (state_r == ST_IDLE) && original_engine_valid;  // leaving idle
	assign run_done   = done_r;

endmodule

/* dma_bench_macros.svh */
// shared constants, NITERATIONS must be at least 1 and REPLAY_MODE only 1 or 2 is supported
`ifndef DMA_BENCH_MACROS_SVH
`define DMA_BENCH_MACROS_SVH

// request stream widths
`define BUS_DATA_WIDTH 256  // rq tdata bits
`define BUS_KEEP_WIDTH 8    // one keep bit per dword
`define RQ_USER_WIDTH  60   // rq tuser bits

// operation field inside the first rq beat (descriptor header)
`define RQ_OP_LSB 75  // low bit of req type
`define RQ_OP_MSB 78  // high bit of req type

// replay control
`define NITERATIONS 8  // transfers issued per user descriptor
`define REPLAY_MODE 1  // 1 same address, 2 successive addresses
`define DRAIN_CYCLES 3 // idle wait after last transfer

// control byte layout
`define CTRL_EOP_BIT 3 // end of operation strobe

`endif

/* dma_bench_pkg.sv */
// shared types for the dma benchmarking shim, widths come from the macros header
`include "dma_bench_macros.svh"

package dma_bench_pkg;

	// descriptor and statistics words
	typedef logic [63:0] word64_t;  // address, size, time, bytes, latency

	typedef logic [7:0] ctrl_byte_t;  // engine control byte

	// request stream payload
	typedef logic [`BUS_DATA_WIDTH-1:0] rq_data_t;  // tdata
	typedef logic [`BUS_KEEP_WIDTH-1:0] rq_keep_t;  // tkeep
	typedef logic [`RQ_USER_WIDTH-1:0]  rq_user_t;  // tuser

	// tlp request type, zero is memory read
	typedef logic [`RQ_OP_MSB-`RQ_OP_LSB:0] rq_op_t;

	typedef logic [31:0] iter_t;  // replay iteration count

	// descriptor replay states
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,  // waiting for the user descriptor
		ST_BUSY  = 2'd1,  // replaying transfers
		ST_DRAIN = 2'd2   // fixed wait before reporting
	} replay_state_t;

endpackage

/* dma_bench_top.sv */
// request stream passes through with no storage, back-pressure comes only from the pcie core
`timescale 1ns/1ps
`include "dma_bench_macros.svh"

module dma_bench_top (
	input  logic                      CLK,
	input  logic                      RST_N,
	// descriptor side
	input  logic                      original_engine_valid,
	input  dma_bench_pkg::word64_t    original_size,
	input  dma_bench_pkg::word64_t    original_addr,
	input  dma_bench_pkg::ctrl_byte_t original_control_byte,
	output logic                      faked_engine_valid,
	output dma_bench_pkg::word64_t    faked_size,
	output dma_bench_pkg::word64_t    faked_addr,
	output dma_bench_pkg::ctrl_byte_t faked_control_byte,
	// request stream from the engine
	input  dma_bench_pkg::rq_data_t   m_axis_rq_tdata,
	input  dma_bench_pkg::rq_user_t   m_axis_rq_tuser,
	input  logic                      m_axis_rq_tlast,
	input  dma_bench_pkg::rq_keep_t   m_axis_rq_tkeep,
	input  logic                      m_axis_rq_tvalid,
	output logic                      m_axis_rq_tready,
	// request stream to the pcie core
	output dma_bench_pkg::rq_data_t   faked_axis_rq_tdata,
	output dma_bench_pkg::rq_user_t   faked_axis_rq_tuser,
	output logic                      faked_axis_rq_tlast,
	output dma_bench_pkg::rq_keep_t   faked_axis_rq_tkeep,
	output logic                      faked_axis_rq_tvalid,
	input  logic                      faked_axis_rq_tready,
	// completion stream, observed only
	input  logic                      s_axis_rc_tvalid,
	input  logic                      s_axis_rc_tready,
	// statistics side
	input  logic                      original_update_latency,
	input  dma_bench_pkg::word64_t    original_time_at_req,
	input  dma_bench_pkg::word64_t    original_time_at_comp,
	input  dma_bench_pkg::word64_t    original_bytes_at_req,
	input  dma_bench_pkg::word64_t    original_bytes_at_comp,
	output logic                      faked_update_latency,
	output dma_bench_pkg::word64_t    faked_current_latency,
	output dma_bench_pkg::word64_t    faked_time_at_req,
	output dma_bench_pkg::word64_t    faked_time_at_comp,
	output dma_bench_pkg::word64_t    faked_bytes_at_req,
	output dma_bench_pkg::word64_t    faked_bytes_at_comp
);

	logic req_start;    // header beat accepted
	logic req_is_read;  // current tlp is a memory read
	logic run_active;   // replay in progress
	logic run_start;    // replay begins
	logic run_done;     // replay finished
	logic rq_fire;      // request beat transfer
	logic rc_fire;      // completion beat transfer

	// zero latency pass-through
	assign faked_axis_rq_tdata  = m_axis_rq_tdata;
	assign faked_axis_rq_tuser  = m_axis_rq_tuser;
	assign faked_axis_rq_tlast  = m_axis_rq_tlast;
	assign faked_axis_rq_tkeep  = m_axis_rq_tkeep;
	assign faked_axis_rq_tvalid = m_axis_rq_tvalid;
	assign m_axis_rq_tready     = faked_axis_rq_tready;

	assign rq_fire = m_axis_rq_tvalid && faked_axis_rq_tready;
	assign rc_fire = s_axis_rc_tvalid && s_axis_rc_tready;

	rq_header_decode i_rq_header_decode (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.rq_tvalid   (m_axis_rq_tvalid),
		.rq_tready   (faked_axis_rq_tready),
		.rq_tlast    (m_axis_rq_tlast),
		.rq_tdata    (m_axis_rq_tdata),
		.req_start   (req_start),
		.req_is_read (req_is_read)
	);

	descriptor_replay #(
		.REPLAY_MODE (`REPLAY_MODE)
	) i_descriptor_replay (
		.CLK                   (CLK),
		.RST_N                 (RST_N),
		.original_engine_valid (original_engine_valid),
		.original_size         (original_size),
		.original_addr         (original_addr),
		.original_control_byte (original_control_byte),
		.faked_engine_valid    (faked_engine_valid),
		.faked_size            (faked_size),
		.faked_addr            (faked_addr),
		.faked_control_byte    (faked_control_byte),
		.run_active            (run_active),
		.run_start             (run_start),
		.run_done              (run_done)
	);

	bench_stats i_bench_stats (
		.CLK                     (CLK),
		.RST_N                   (RST_N),
		.req_start               (req_start),
		.req_is_read             (req_is_read),
		.rq_fire                 (rq_fire),
		.rc_fire                 (rc_fire),
		.run_active              (run_active),
		.run_start               (run_start),
		.run_done                (run_done),
		.original_update_latency (original_update_latency),
		.original_time_at_req    (original_time_at_req),
		.original_time_at_comp   (original_time_at_comp),
		.original_bytes_at_req   (original_bytes_at_req),
		.original_bytes_at_comp  (original_bytes_at_comp),
		.faked_update_latency    (faked_update_latency),
		.faked_current_latency   (faked_current_latency),
		.faked_time_at_req       (faked_time_at_req),
		.faked_time_at_comp      (faked_time_at_comp),
		.faked_bytes_at_req      (faked_bytes_at_req),
		.faked_bytes_at_comp     (faked_bytes_at_comp)
	);

endmodule

/* files.f */
+incdir+.
dma_bench_pkg.sv
rq_header_decode.sv
descriptor_replay.sv
bench_stats.sv
dma_bench_top.sv
tb_clock_gen.sv
tb_dma_bench.sv

/* rq_header_decode.sv */
// assumes the first accepted beat of every tlp carries the descriptor header, no mid-packet resync
`timescale 1ns/1ps
`include "dma_bench_macros.svh"

module rq_header_decode (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    rq_tvalid,
	input  logic                    rq_tready,
	input  logic                    rq_tlast,
	input  dma_bench_pkg::rq_data_t rq_tdata,
	output logic                    req_start,
	output logic                    req_is_read
);
	import dma_bench_pkg::*;

	logic   sop_r;        // next accepted beat opens a tlp
	logic   beat_fire;    // beat accepted this cycle
	rq_op_t op;           // request type of the current beat
	logic   op_is_read;   // header says memory read
	logic   is_read_r;    // held read flag of the last header

	assign beat_fire = rq_tvalid && rq_tready;
	assign op        = rq_tdata[`RQ_OP_MSB:`RQ_OP_LSB];
	assign op_is_read = (op == rq_op_t'(0));

	// header beat marker, same cycle as the accepted beat
	assign req_start = beat_fire && sop_r;

	// start of packet tracking
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			sop_r <= 1'b1;  // first beat after reset is a header
		end else if (beat_fire) begin
			sop_r <= rq_tlast;  // rearm after the last beat
		end
	end

	// remember the request type until the next header
	always_ff @(posedge CLK) begin
		if (!RST_N) begin
			is_read_r <= 1'b0;
		end else if (req_start) begin
			is_read_r <= op_is_read;
		end
	end

	// header cycle uses the live decode, later cycles the held one
	assign req_is_read = req_start ? op_is_read : is_read_r;

endmodule

/* tb_clock_gen.sv */
// clock and synchronous reset for the testbench, reset releases on a falling edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 50,  // ns, gives a 100 ns clock
	parameter int RESET_CYCLES = 10   // rising edges with reset low
) (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD) CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);  // release away from the sampling edge
		RST_N = 1'b1;
	end

endmodule

/* tb_dma_bench.sv */
// needs REPLAY_MODE 1 or 2 and DRAIN_CYCLES below 250 for the random replay runs
`timescale 1ns/1ps
`include "dma_bench_macros.svh"

module tb_dma_bench;
	import dma_bench_pkg::*;

	localparam int NUM_RUNS        = 12;
	localparam int MAX_GAP         = 6;  // most cycles per transfer including the strobe
	localparam int WATCHDOG_CYCLES = NUM_RUNS * `NITERATIONS * MAX_GAP + 200;
	localparam int CAT_REPLAY      = 0;
	localparam int CAT_CTRL        = 1;
	localparam int CAT_PASS        = 2;
	localparam int CAT_STATS       = 3;
	localparam int CAT_LATENCY     = 4;
	localparam int CAT_OTHER       = 5;

	logic       CLK, RST_N;
	logic       original_engine_valid, faked_engine_valid;
	word64_t    original_size, original_addr, faked_size, faked_addr;
	ctrl_byte_t original_control_byte, faked_control_byte;
	rq_data_t   m_axis_rq_tdata, faked_axis_rq_tdata;
	rq_user_t   m_axis_rq_tuser, faked_axis_rq_tuser;
	rq_keep_t   m_axis_rq_tkeep, faked_axis_rq_tkeep;
	logic       m_axis_rq_tlast, m_axis_rq_tvalid, m_axis_rq_tready;
	logic       faked_axis_rq_tlast, faked_axis_rq_tvalid, faked_axis_rq_tready;
	logic       s_axis_rc_tvalid, s_axis_rc_tready;
	logic       original_update_latency, faked_update_latency;
	word64_t    original_time_at_req, original_time_at_comp;
	word64_t    original_bytes_at_req, original_bytes_at_comp;
	word64_t    faked_current_latency, faked_time_at_req, faked_time_at_comp;
	word64_t    faked_bytes_at_req, faked_bytes_at_comp;

	integer        seed = 32'haad2;
	int            err_cnt[6];
	int            cyc;             // falling edges since reset release
	int            final_eop_cyc;   // cycle the last strobe of a run was driven
	int            pulses;          // update pulses seen in this run
	int            strobes;         // eop strobes driven in this run
	logic          prev_ev;
	replay_state_t exp_state;       // model of the replay fsm
	iter_t         exp_iter;
	word64_t       exp_addr, exp_size;
	logic          exp_ev, exp_done, exp_upd;
	int            exp_drain;
	logic          exp_sop, exp_is_read, exp_counting;
	word64_t       exp_cnt, exp_snap, exp_treq, exp_tcomp, exp_breq, exp_bcomp;

	tb_clock_gen i_clock_gen (.CLK(CLK), .RST_N(RST_N));

	dma_bench_top i_dut (.*);

	task automatic report_mismatch(input int cat, input string what,
			input logic [255:0] got, input logic [255:0] exp);
		err_cnt[cat]++;
		$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
	endtask

	// advance the model by the clock edge that just sampled the current inputs
	task automatic model_clock();
		logic eop, rq_fire, rc_fire, start, is_read, snap, active, run_start;
		eop       = original_control_byte[`CTRL_EOP_BIT];
		rq_fire   = m_axis_rq_tvalid && faked_axis_rq_tready;
		rc_fire   = s_axis_rc_tvalid && s_axis_rc_tready;
		start     = rq_fire && exp_sop;  // first beat of a tlp
		is_read   = start ? (m_axis_rq_tdata[`RQ_OP_MSB:`RQ_OP_LSB] == 0) : exp_is_read;
		snap      = is_read ? rc_fire : rq_fire;
		active    = (exp_state != ST_IDLE);
		run_start = (exp_state == ST_IDLE) && original_engine_valid;
		if (snap)
			exp_snap = exp_cnt + 1;  // old count plus the closing beat
		if (!active) begin
			exp_cnt      = 0;
			exp_counting = 1'b0;
		end else if (exp_counting || start) begin
			exp_cnt      = exp_cnt + 1;
			exp_counting = 1'b1;
		end
		if (original_update_latency) begin
			exp_treq  = (run_start ? 64'd0 : exp_treq) + original_time_at_req;
			exp_tcomp = (run_start ? 64'd0 : exp_tcomp) + original_time_at_comp;
			exp_breq  = original_bytes_at_req * 64'(`NITERATIONS);
			exp_bcomp = original_bytes_at_comp * 64'(`NITERATIONS);
		end else if (run_start) begin
			exp_treq  = 0;
			exp_tcomp = 0;
		end
		exp_upd     = exp_done;  // pulse one cycle after the run ends
		exp_done    = 1'b0;
		exp_is_read = is_read;
		if (rq_fire)
			exp_sop = m_axis_rq_tlast;
		case (exp_state)
			ST_IDLE: begin
				exp_size = original_size;  // idle follows the inputs
				exp_addr = original_addr;
				exp_iter = 1;
				exp_ev   = original_engine_valid;
				if (original_engine_valid)
					exp_state = ST_BUSY;
			end
			ST_BUSY: if (eop) begin
				exp_addr = (`REPLAY_MODE == 2) ? exp_addr + exp_size : original_addr;
				exp_size = original_size;
				if (exp_iter == `NITERATIONS) begin
					exp_state = ST_DRAIN;
					exp_ev    = 1'b0;
					exp_drain = `DRAIN_CYCLES;
				end
				exp_iter = exp_iter + 1;
			end
			default: begin
				if (exp_drain == 0) begin
					exp_state = ST_IDLE;
					exp_done  = 1'b1;
				end
				exp_drain = exp_drain - 1;
			end
		endcase
	endtask

	task automatic check_registered();
		if (faked_engine_valid !== exp_ev)
			report_mismatch(CAT_REPLAY, "faked_engine_valid", faked_engine_valid, exp_ev);
		if (faked_addr !== exp_addr)
			report_mismatch(CAT_REPLAY, "faked_addr", faked_addr, exp_addr);
		if (faked_size !== exp_size)
			report_mismatch(CAT_REPLAY, "faked_size", faked_size, exp_size);
		if (prev_ev && !faked_engine_valid && strobes != `NITERATIONS)
			report_mismatch(CAT_REPLAY, "strobes before engine valid fell", strobes, `NITERATIONS);
		prev_ev = faked_engine_valid;
		if (faked_update_latency !== exp_upd)
			report_mismatch(CAT_STATS, "faked_update_latency", faked_update_latency, exp_upd);
		if (faked_update_latency === 1'b1) begin
			pulses++;
			if (cyc - final_eop_cyc != `DRAIN_CYCLES + 3)  // strobe cycle to pulse cycle
				report_mismatch(CAT_STATS, "update pulse delay", cyc - final_eop_cyc,
					`DRAIN_CYCLES + 3);
		end
		if (faked_time_at_req !== exp_treq)
			report_mismatch(CAT_STATS, "faked_time_at_req", faked_time_at_req, exp_treq);
		if (faked_time_at_comp !== exp_tcomp)
			report_mismatch(CAT_STATS, "faked_time_at_comp", faked_time_at_comp, exp_tcomp);
		if (faked_bytes_at_req !== exp_breq)
			report_mismatch(CAT_STATS, "faked_bytes_at_req", faked_bytes_at_req, exp_breq);
		if (faked_bytes_at_comp !== exp_bcomp)
			report_mismatch(CAT_STATS, "faked_bytes_at_comp", faked_bytes_at_comp, exp_bcomp);
		if (faked_current_latency !== exp_snap)
			report_mismatch(CAT_LATENCY, "faked_current_latency", faked_current_latency, exp_snap);
	endtask

	task automatic drive_inputs(input logic ev, input logic eop);
		original_engine_valid = ev;
		original_size         = word64_t'({$random(seed)} & 32'h000f_fff0);  // aligned sizes
		original_addr         = {$random(seed), $random(seed)};
		original_control_byte = ctrl_byte_t'($random(seed));  // noise on the other bits
		original_control_byte[`CTRL_EOP_BIT] = eop;
		for (int i = 0; i < `BUS_DATA_WIDTH / 32; i++)
			m_axis_rq_tdata[i*32 +: 32] = $random(seed);
		m_axis_rq_tdata[`RQ_OP_MSB:`RQ_OP_LSB] = rq_op_t'({$random(seed)} % 2);  // read or write
		m_axis_rq_tuser         = rq_user_t'({$random(seed), $random(seed)});
		m_axis_rq_tkeep         = rq_keep_t'($random(seed));
		m_axis_rq_tlast         = ({$random(seed)} % 3) == 0;
		m_axis_rq_tvalid        = ({$random(seed)} % 2) == 0;
		faked_axis_rq_tready    = ({$random(seed)} % 4) != 0;
		s_axis_rc_tvalid        = ({$random(seed)} % 2) == 0;
		s_axis_rc_tready        = ({$random(seed)} % 2) == 0;
		original_update_latency = ({$random(seed)} % 6) == 0;
		original_time_at_req    = word64_t'({$random(seed)});
		original_time_at_comp   = word64_t'({$random(seed)});
		original_bytes_at_req   = word64_t'({$random(seed)});
		original_bytes_at_comp  = word64_t'({$random(seed)});
	endtask

	// outputs that follow the inputs in the same cycle
	task automatic check_comb();
		ctrl_byte_t exp_ctrl;
		exp_ctrl = '0;
		exp_ctrl[`CTRL_EOP_BIT] = original_control_byte[`CTRL_EOP_BIT] &&
			(strobes == `NITERATIONS);  // only the last strobe driven in this run
		if (faked_control_byte !== exp_ctrl)
			report_mismatch(CAT_CTRL, "faked_control_byte", faked_control_byte, exp_ctrl);
		if (faked_axis_rq_tdata !== m_axis_rq_tdata)
			report_mismatch(CAT_PASS, "faked_axis_rq_tdata", faked_axis_rq_tdata, m_axis_rq_tdata);
		if (faked_axis_rq_tuser !== m_axis_rq_tuser)
			report_mismatch(CAT_PASS, "faked_axis_rq_tuser", faked_axis_rq_tuser, m_axis_rq_tuser);
		if (faked_axis_rq_tkeep !== m_axis_rq_tkeep)
			report_mismatch(CAT_PASS, "faked_axis_rq_tkeep", faked_axis_rq_tkeep, m_axis_rq_tkeep);
		if (faked_axis_rq_tlast !== m_axis_rq_tlast)
			report_mismatch(CAT_PASS, "faked_axis_rq_tlast", faked_axis_rq_tlast, m_axis_rq_tlast);
		if (faked_axis_rq_tvalid !== m_axis_rq_tvalid)
			report_mismatch(CAT_PASS, "faked_axis_rq_tvalid", faked_axis_rq_tvalid,
				m_axis_rq_tvalid);
		if (m_axis_rq_tready !== faked_axis_rq_tready)
			report_mismatch(CAT_PASS, "m_axis_rq_tready", m_axis_rq_tready, faked_axis_rq_tready);
	endtask

	// one clock with model and registered checks followed by new inputs and same cycle checks
	task automatic step(input logic ev, input logic eop);
		@(negedge CLK);
		cyc++;
		model_clock();
		check_registered();
		drive_inputs(ev, eop);
		#1;
		check_comb();
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		int waited;
		int total;
		original_engine_valid = 1'b0;  // quiet inputs through reset
		original_size = '0;
		original_addr = '0;
		original_control_byte = '0;
		m_axis_rq_tdata = '0;
		m_axis_rq_tuser = '0;
		m_axis_rq_tkeep = '0;
		m_axis_rq_tlast = 1'b0;
		m_axis_rq_tvalid = 1'b0;
		faked_axis_rq_tready = 1'b0;
		s_axis_rc_tvalid = 1'b0;
		s_axis_rc_tready = 1'b0;
		original_update_latency = 1'b0;
		original_time_at_req = '0;
		original_time_at_comp = '0;
		original_bytes_at_req = '0;
		original_bytes_at_comp = '0;
		foreach (err_cnt[k])
			err_cnt[k] = 0;
		cyc = 0;
		final_eop_cyc = 0;
		pulses = 0;
		strobes = 0;
		prev_ev = 1'b0;
		exp_state = ST_IDLE;  // reset values of the model
		exp_iter = 1;
		exp_addr = '0;
		exp_size = '0;
		exp_ev = 1'b0;
		exp_done = 1'b0;
		exp_upd = 1'b0;
		exp_drain = 0;
		exp_sop = 1'b1;
		exp_is_read = 1'b0;
		exp_counting = 1'b0;
		exp_cnt = '0;
		exp_snap = '0;
		exp_treq = '0;
		exp_tcomp = '0;
		exp_breq = '0;
		exp_bcomp = '0;
		wait (RST_N === 1'b1);
		for (int run = 0; run < NUM_RUNS; run++) begin
			strobes = 0;
			pulses = 0;
			repeat (1 + {$random(seed)} % 3) step(1'b0, 1'b0);  // idle lead in
			step(1'b1, 1'b0);  // user descriptor
			for (int it = 1; it <= `NITERATIONS; it++) begin
				repeat ({$random(seed)} % MAX_GAP) step(1'b0, 1'b0);
				final_eop_cyc = cyc + 1;
				strobes++;
				step(1'b0, 1'b1);
			end
			waited = 0;
			while (pulses == 0 && waited < `DRAIN_CYCLES + 10) begin
				step(1'b0, 1'b0);
				waited++;
			end
			step(1'b0, 1'b0);  // a second pulse would show here
			if (pulses != 1) begin
				$display("run %0d gave %0d update pulses instead of one", run, pulses);
				err_cnt[CAT_OTHER]++;
			end
		end
		repeat (4) step(1'b0, 1'b0);
		total = 0;
		foreach (err_cnt[k])
			total += err_cnt[k];
		$display("errors: replay %0d, ctrl %0d, pass %0d, stats %0d, latency %0d, other %0d",
			err_cnt[CAT_REPLAY], err_cnt[CAT_CTRL], err_cnt[CAT_PASS], err_cnt[CAT_STATS],
			err_cnt[CAT_LATENCY], err_cnt[CAT_OTHER]);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
